// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
DUT_TOP   ?= fetch_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST) include/fetch_macros.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then echo "No pass message"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+include
hw/fetch_types_pkg.sv
hw/mem_types_pkg.sv
hw/itlb.sv
hw/iptw.sv
hw/instr_cache.sv
hw/fetch_stage.sv
hw/fetch_top.sv
verification/tb_clock_gen.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_stage import fetch_types_pkg::*; import mem_types_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         vm_en_i,
  input  logic         trap_bypass_mmu_i,
  input  satp_t        satp_data_i,
  input  logic         flush_i,
  input  vaddr_t       next_pc_flush_i,
  input  logic         alu_branch_taken_i,
  input  vaddr_t       pc_branch_offset_i,
  input  logic         is_jump_i,
  input  vaddr_t       jump_address_i,
  input  logic         dec_stall_i,
  output logic         present_table_req_o,
  output ppn_t         present_table_ppn_o,
  input  logic         ppn_is_present_i,
  output logic         rd_req_valid_o,
  output paddr_t       mem_req_addr_o,
  output access_size_t req_access_size_o,
  input  logic         mem_gnt_i,
  input  logic         instr_valid_i,
  input  cache_line_t  instr_line_i,
  output logic         dec_valid_o,
  output logic         dec_excpt_o,
  output excpt_cause_t dec_excpt_cause_o,
  output vaddr_t       dec_pc_o,
  output instruction_t dec_instr_o
);

  typedef enum logic [2:0] {
    IDLE,
    MEM_REQ,
    MEM_WAIT,
    STALL,
    FLUSH
  } state_t;

  state_t state_q, state_d;
  vaddr_t pc_q, pc_d;
  vaddr_t pc_seq;
  paddr_t paddr;
  logic   mmu_enable;
  logic   take_item;

  // One entry stall buffer
  logic         buf_wr_en;
  vaddr_t       buf_pc_q;
  instruction_t buf_instr_q;
  logic         buf_excpt_q, buf_excpt_d;
  excpt_cause_t buf_cause_q, buf_cause_d;

  logic   itlb_hit;
  logic   itlb_wr_en;
  ppn_t   itlb_ppn;

  logic   iptw_req;
  logic   iptw_valid;
  logic   iptw_error;
  paddr_t iptw_paddr;

  logic         cache_state_reset;
  logic         cache_req;
  logic         cache_hit;
  logic         cache_ready;
  logic         cache_rvalid;
  instruction_t cache_rdata;

  itlb i_itlb (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .wr_en_i (itlb_wr_en),
    .vpn_i   (vpn_t'(pc_q[`FETCH_ADDR_WIDTH-1:12])),
    .ppn_i   (iptw_paddr[`FETCH_PADDR_WIDTH-1:12]),
    .hit_o   (itlb_hit),
    .ppn_o   (itlb_ppn)
  );

  iptw i_iptw (
    .req_i            (iptw_req),
    .ppn_is_present_i (ppn_is_present_i),
    .vaddr_i          (pc_q),
    .satp_data_i      (satp_data_i),
    .valid_o          (iptw_valid),
    .error_o          (iptw_error),
    .paddr_o          (iptw_paddr)
  );

  instr_cache i_instr_cache (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .state_reset_i    (cache_state_reset),
    .cpu_req_i        (cache_req),
    .cpu_addr_i       (paddr),
    .cpu_ready_o      (cache_ready),
    .cpu_rdata_o      (cache_rdata),
    .cpu_rvalid_o     (cache_rvalid),
    .curr_cache_hit_o (cache_hit),
    .mem_req_o        (rd_req_valid_o),
    .mem_addr_o       (mem_req_addr_o),
    .mem_gnt_i        (mem_gnt_i),
    .mem_rvalid_i     (instr_valid_i),
    .mem_rdata_i      (instr_line_i)
  );

  assign mmu_enable        = vm_en_i && !trap_bypass_mmu_i;
  assign req_access_size_o = WORD;
  assign pc_seq            = vaddr_t'((pc_q + 32'd4) % `FETCH_MEM_SIZE);

  // Bare, ITLB hit or walked address
  always_comb begin
    if (!mmu_enable) begin
      paddr = pc_q[`FETCH_PADDR_WIDTH-1:0];
    end else if (itlb_hit) begin
      paddr = {itlb_ppn, pc_q[11:0]};
    end else begin
      paddr = iptw_paddr;
    end
  end

  always_comb begin
    state_d             = state_q;
    pc_d                = pc_q;
    take_item           = 1'b0;
    itlb_wr_en          = 1'b0;
    iptw_req            = 1'b0;
    present_table_req_o = 1'b0;
    present_table_ppn_o = '0;
    cache_req           = 1'b0;
    cache_state_reset   = 1'b0;
    buf_wr_en           = 1'b0;
    buf_excpt_d         = 1'b0;
    buf_cause_d         = EXC_NONE;
    dec_valid_o         = 1'b0;
    dec_excpt_o         = 1'b0;
    dec_excpt_cause_o   = EXC_NONE;
    dec_pc_o            = pc_q;
    dec_instr_o         = '0;

    if (flush_i) begin
      // Outstanding refill must drain before the new fetch
      pc_d    = next_pc_flush_i;
      state_d = cache_ready ? MEM_REQ : FLUSH;
    end else if (alu_branch_taken_i || is_jump_i) begin
      cache_state_reset = 1'b1;
      pc_d              = alu_branch_taken_i ? pc_branch_offset_i : jump_address_i;
      state_d           = MEM_REQ;
    end else begin
      case (state_q)
        IDLE: begin
          state_d = MEM_REQ;
        end
        MEM_REQ: begin
          if (mmu_enable && !itlb_hit) begin
            iptw_req            = 1'b1;
            present_table_req_o = 1'b1;
            present_table_ppn_o = iptw_paddr[`FETCH_PADDR_WIDTH-1:12];
            itlb_wr_en          = iptw_valid;
          end

          if (iptw_error) begin
            dec_valid_o       = 1'b1;
            dec_excpt_o       = 1'b1;
            dec_excpt_cause_o = EXC_INSTR_PAGE_FAULT;
            // PC holds so the same address is tried again
            if (dec_stall_i) begin
              buf_wr_en   = 1'b1;
              buf_excpt_d = 1'b1;
              buf_cause_d = EXC_INSTR_PAGE_FAULT;
              state_d     = STALL;
            end
          end else begin
            cache_req = 1'b1;
            if (cache_hit && cache_rvalid) begin
              take_item = 1'b1;
            end else begin
              state_d = MEM_WAIT;
            end
          end
        end
        MEM_WAIT: begin
          // Kept high so a request the cache was too busy to take is not lost
          cache_req = 1'b1;
          take_item = cache_rvalid;
        end
        STALL: begin
          dec_valid_o       = 1'b1;
          dec_excpt_o       = buf_excpt_q;
          dec_excpt_cause_o = buf_cause_q;
          dec_pc_o          = buf_pc_q;
          dec_instr_o       = buf_instr_q;
          if (!dec_stall_i) begin
            pc_d    = buf_excpt_q ? pc_q : pc_seq;
            state_d = MEM_REQ;
          end
        end
        FLUSH: begin
          if (cache_ready) begin
            state_d = MEM_REQ;
          end
        end
        default: state_d = IDLE;
      endcase

      if (take_item) begin
        dec_valid_o = 1'b1;
        dec_instr_o = cache_rdata;
        if (dec_stall_i) begin
          buf_wr_en = 1'b1;
          state_d   = STALL;
        end else begin
          pc_d    = pc_seq;
          state_d = MEM_REQ;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q     <= IDLE;
      pc_q        <= `FETCH_RESET_PC;
      buf_excpt_q <= 1'b0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      if (buf_wr_en) begin
        buf_excpt_q <= buf_excpt_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_wr_en) begin
      buf_pc_q    <= pc_q;
      buf_instr_q <= cache_rdata;
      buf_cause_q <= buf_cause_d;
    end
  end

endmodule : fetch_stage

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_types_pkg::*; import mem_types_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         vm_en_i,
  input  logic         trap_bypass_mmu_i,
  input  satp_t        satp_data_i,
  input  logic         flush_i,
  input  vaddr_t       next_pc_flush_i,
  input  logic         alu_branch_taken_i,
  input  vaddr_t       pc_branch_offset_i,
  input  logic         is_jump_i,
  input  vaddr_t       jump_address_i,
  input  logic         dec_stall_i,
  output logic         present_table_req_o,
  output ppn_t         present_table_ppn_o,
  input  logic         ppn_is_present_i,
  output logic         rd_req_valid_o,
  output paddr_t       mem_req_addr_o,
  output access_size_t req_access_size_o,
  input  logic         mem_gnt_i,
  input  logic         instr_valid_i,
  input  cache_line_t  instr_line_i,
  output logic         dec_valid_o,
  output logic         dec_excpt_o,
  output excpt_cause_t dec_excpt_cause_o,
  output vaddr_t       dec_pc_o,
  output instruction_t dec_instr_o
);

  fetch_stage i_fetch_stage (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .vm_en_i             (vm_en_i),
    .trap_bypass_mmu_i   (trap_bypass_mmu_i),
    .satp_data_i         (satp_data_i),
    .flush_i             (flush_i),
    .next_pc_flush_i     (next_pc_flush_i),
    .alu_branch_taken_i  (alu_branch_taken_i),
    .pc_branch_offset_i  (pc_branch_offset_i),
    .is_jump_i           (is_jump_i),
    .jump_address_i      (jump_address_i),
    .dec_stall_i         (dec_stall_i),
    .present_table_req_o (present_table_req_o),
    .present_table_ppn_o (present_table_ppn_o),
    .ppn_is_present_i    (ppn_is_present_i),
    .rd_req_valid_o      (rd_req_valid_o),
    .mem_req_addr_o      (mem_req_addr_o),
    .req_access_size_o   (req_access_size_o),
    .mem_gnt_i           (mem_gnt_i),
    .instr_valid_i       (instr_valid_i),
    .instr_line_i        (instr_line_i),
    .dec_valid_o         (dec_valid_o),
    .dec_excpt_o         (dec_excpt_o),
    .dec_excpt_cause_o   (dec_excpt_cause_o),
    .dec_pc_o            (dec_pc_o),
    .dec_instr_o         (dec_instr_o)
  );

endmodule : fetch_top

// ==== hw/fetch_types_pkg.sv ====
`include "fetch_macros.svh"

package fetch_types_pkg;

  // Core side addresses
  typedef logic [`FETCH_ADDR_WIDTH-1:0] vaddr_t;
  typedef logic [`FETCH_VPN_WIDTH-1:0]  vpn_t;
  typedef logic [`FETCH_PPN_WIDTH-1:0]  ppn_t;

  typedef logic [31:0] instruction_t;

  // Low byte holds the root page
  typedef logic [31:0] satp_t;

  typedef logic [3:0] excpt_cause_t;

  localparam excpt_cause_t EXC_NONE             = 4'd0;
  localparam excpt_cause_t EXC_INSTR_PAGE_FAULT = 4'd12;

endpackage : fetch_types_pkg

// ==== hw/instr_cache.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module instr_cache import fetch_types_pkg::*; import mem_types_pkg::*; #(
  parameter int LINES = `FETCH_CACHE_LINES
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         state_reset_i,
  input  logic         cpu_req_i,
  input  paddr_t       cpu_addr_i,
  output logic         cpu_ready_o,
  output instruction_t cpu_rdata_o,
  output logic         cpu_rvalid_o,
  output logic         curr_cache_hit_o,
  output logic         mem_req_o,
  output paddr_t       mem_addr_o,
  input  logic         mem_gnt_i,
  input  logic         mem_rvalid_i,
  input  cache_line_t  mem_rdata_i
);

  localparam int OFFSET_BITS = $clog2(`FETCH_LINE_BYTES);
  localparam int INDEX_BITS  = $clog2(LINES);
  localparam int TAG_BITS    = $bits(paddr_t) - INDEX_BITS - OFFSET_BITS;
  localparam int WSEL_BITS   = OFFSET_BITS - 2;

  typedef enum logic [1:0] {
    C_IDLE,
    C_REQ,
    C_WAIT,
    C_FILL
  } cache_state_t;

  cache_state_t state_q;

  logic [LINES-1:0]    valid_q;
  logic [TAG_BITS-1:0] tag_q  [LINES];
  cache_line_t         data_q [LINES];

  // Address of the refill in flight
  paddr_t req_addr_q;
  logic   drop_q;

  logic [INDEX_BITS-1:0] cpu_index;
  logic [TAG_BITS-1:0]   cpu_tag;
  logic                  tag_match;
  logic                  lookup_hit;
  logic                  miss_accept;

  paddr_t                rd_addr;
  logic [INDEX_BITS-1:0] rd_index;
  logic [WSEL_BITS-1:0]  rd_word;
  logic [INDEX_BITS-1:0] fill_index;

  assign cpu_index = cpu_addr_i[OFFSET_BITS +: INDEX_BITS];
  assign cpu_tag   = cpu_addr_i[$bits(paddr_t)-1 -: TAG_BITS];
  assign tag_match = valid_q[cpu_index] && (tag_q[cpu_index] == cpu_tag);

  assign lookup_hit  = (state_q == C_IDLE) && cpu_req_i && tag_match;
  assign miss_accept = (state_q == C_IDLE) && cpu_req_i && !tag_match;

  // After a refill the word comes from the line just written
  assign rd_addr     = (state_q == C_FILL) ? req_addr_q : cpu_addr_i;
  assign rd_index    = rd_addr[OFFSET_BITS +: INDEX_BITS];
  assign rd_word     = rd_addr[2 +: WSEL_BITS];
  assign cpu_rdata_o = data_q[rd_index][rd_word*32 +: 32];

  assign fill_index = req_addr_q[OFFSET_BITS +: INDEX_BITS];

  assign curr_cache_hit_o = lookup_hit;
  assign cpu_ready_o      = (state_q == C_IDLE);
  assign cpu_rvalid_o     = lookup_hit ||
                            ((state_q == C_FILL) && !drop_q && !state_reset_i);

  assign mem_req_o  = (state_q == C_REQ);
  assign mem_addr_o = {req_addr_q[$bits(paddr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= C_IDLE;
      valid_q <= '0;
      drop_q  <= 1'b0;
    end else begin
      case (state_q)
        C_IDLE: begin
          if (miss_accept) begin
            state_q <= C_REQ;
            drop_q  <= 1'b0;
          end
        end
        C_REQ: begin
          if (mem_gnt_i) begin
            state_q <= C_WAIT;
          end
        end
        C_WAIT: begin
          if (mem_rvalid_i) begin
            state_q             <= C_FILL;
            valid_q[fill_index] <= 1'b1;
          end
        end
        C_FILL: begin
          state_q <= C_IDLE;
        end
        default: state_q <= C_IDLE;
      endcase

      // Refill still runs to the end but its word is not returned
      if (state_reset_i && (state_q != C_IDLE)) begin
        drop_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_accept) begin
      req_addr_q <= cpu_addr_i;
    end
    if ((state_q == C_WAIT) && mem_rvalid_i) begin
      data_q[fill_index] <= mem_rdata_i;
      tag_q[fill_index]  <= req_addr_q[$bits(paddr_t)-1 -: TAG_BITS];
    end
  end

endmodule : instr_cache

// ==== hw/iptw.sv ====
`timescale 1ns/1ps

module iptw import fetch_types_pkg::*; import mem_types_pkg::*; (
  input  logic   req_i,
  input  logic   ppn_is_present_i,
  input  vaddr_t vaddr_i,
  input  satp_t  satp_data_i,
  output logic   valid_o,
  output logic   error_o,
  output paddr_t paddr_o
);

  ppn_t root_ppn;
  ppn_t vpn_low;
  ppn_t walk_ppn;

  assign root_ppn = satp_data_i[$bits(ppn_t)-1:0];
  assign vpn_low  = vaddr_i[12 +: $bits(ppn_t)];

  // Single level table where the page wraps modulo 256
  assign walk_ppn = root_ppn + vpn_low;

  assign paddr_o = {walk_ppn, vaddr_i[11:0]};

  // Present table answers in the same cycle
  assign valid_o = req_i && ppn_is_present_i;
  assign error_o = req_i && !ppn_is_present_i;

endmodule : iptw

// ==== hw/itlb.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module itlb import fetch_types_pkg::*; #(
  parameter int ENTRIES = `FETCH_ITLB_ENTRIES
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic flush_i,
  input  logic wr_en_i,
  input  vpn_t vpn_i,
  input  ppn_t ppn_i,
  output logic hit_o,
  output ppn_t ppn_o
);

  localparam int PTR_W = $clog2(ENTRIES);

  logic [ENTRIES-1:0] valid_q;
  vpn_t               tag_q [ENTRIES];
  ppn_t               ppn_q [ENTRIES];
  logic [PTR_W-1:0]   victim_q;

  // Parallel compare over all entries
  always_comb begin
    hit_o = 1'b0;
    ppn_o = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (valid_q[i] && (tag_q[i] == vpn_i)) begin
        hit_o = 1'b1;
        ppn_o = ppn_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[victim_q] <= 1'b1;
      victim_q          <= victim_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i && !flush_i) begin
      tag_q[victim_q] <= vpn_i;
      ppn_q[victim_q] <= ppn_i;
    end
  end

endmodule : itlb

// ==== hw/mem_types_pkg.sv ====
`include "fetch_macros.svh"

package mem_types_pkg;

  typedef logic [`FETCH_PADDR_WIDTH-1:0] paddr_t;

  // One full refill beat
  typedef logic [`FETCH_LINE_BYTES*8-1:0] cache_line_t;

  typedef logic [1:0] access_size_t;

  // Fetch only ever reads words
  localparam access_size_t WORD = 2'd2;

endpackage : mem_types_pkg

// ==== include/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Address widths
`define FETCH_ADDR_WIDTH   32
`define FETCH_PADDR_WIDTH  20
`define FETCH_PPN_WIDTH    8
`define FETCH_VPN_WIDTH    20

// PC after reset and PC wrap in bytes
`define FETCH_RESET_PC     32'h1000
`define FETCH_MEM_SIZE     32'h100000

// ITLB size
`define FETCH_ITLB_ENTRIES 4

// Instruction cache geometry
`define FETCH_LINE_BYTES   16
`define FETCH_CACHE_LINES  16

`endif

// ==== verification/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker import fetch_types_pkg::*; import mem_types_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         active_i,
  input  logic         valid_i,
  input  logic         stall_i,
  input  logic         excpt_i,
  input  excpt_cause_t cause_i,
  input  vaddr_t       pc_i,
  input  instruction_t instr_i,
  input  logic         walk_req_i,
  input  logic         mem_req_i,
  input  paddr_t       mem_addr_i,
  input  access_size_t size_i
);

  vaddr_t       exp_pc    [$];
  instruction_t exp_instr [$];
  excpt_cause_t exp_cause [$];

  int error_count = 0;
  int item_count  = 0;
  int seen_count  = 0;
  int walk_count  = 0;

  task automatic push_item(input vaddr_t pc, input instruction_t instr,
                           input excpt_cause_t cause);
    exp_pc.push_back(pc);
    exp_instr.push_back(instr);
    exp_cause.push_back(cause);
  endtask

  task automatic start_scenario();
    seen_count = 0;
    walk_count = 0;
  endtask

  task automatic end_scenario(input int exp_walks);
    if (exp_pc.size() != 0) begin
      $display("Missing %0d expected decode items at end of scenario", exp_pc.size());
      error_count++;
      exp_pc.delete();
      exp_instr.delete();
      exp_cause.delete();
    end
    if (walk_count != exp_walks) begin
      $display("FAIL %0t: present table requests %0d, expected %0d",
               $time, walk_count, exp_walks);
      error_count++;
    end
  endtask

  task automatic compare_item();
    vaddr_t       pc;
    instruction_t instr;
    excpt_cause_t cause;
    logic         excpt;
    if (exp_pc.size() == 0) begin
      $display("Extra decode item at PC %h with no expected item left", pc_i);
      error_count++;
    end else begin
      pc    = exp_pc.pop_front();
      instr = exp_instr.pop_front();
      cause = exp_cause.pop_front();
      excpt = (cause != EXC_NONE);
      seen_count++;
      item_count++;
      if (pc_i !== pc) begin
        $display("FAIL %0t: pc %h, expected %h", $time, pc_i, pc);
        error_count++;
      end
      if (excpt_i !== excpt || cause_i !== cause) begin
        $display("FAIL %0t: pc %h exception %b cause %0d, expected %b cause %0d",
                 $time, pc, excpt_i, cause_i, excpt, cause);
        error_count++;
      end
      // Fault items carry no instruction
      if (!excpt && instr_i !== instr) begin
        $display("FAIL %0t: pc %h instruction %h, expected %h", $time, pc, instr_i, instr);
        error_count++;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      // Fetch always reads whole words from line aligned addresses
      if (mem_req_i && size_i !== 2'd2) begin
        $display("FAIL %0t: access size %0d, expected word size 2", $time, size_i);
        error_count++;
      end
      if (mem_req_i && mem_addr_i[3:0] !== 4'h0) begin
        $display("FAIL %0t: memory address %h is not line aligned", $time, mem_addr_i);
        error_count++;
      end
      if (active_i) begin
        if (walk_req_i) begin
          walk_count++;
        end
        if (valid_i && !stall_i) begin
          compare_item();
        end
      end
    end
  end

endmodule : fetch_checker

// ==== verification/fetch_golden.txt ====
# Header: scenario count, total expected items (decimal)
# Record: vm bypass satp(hex) mask(hex) kind(0 none 1 branch 2 jump 3 flush) trigger target(hex) stall walks count
# Item: pc(hex) instruction(hex) cause(hex)
8 44
0 0 00000000 00000000 0 0 00000000 0 0 6
00001000 13001000 0
00001004 13001004 0
00001008 13001008 0
0000100c 1300100c 0
00001010 13001010 0
00001014 13001014 0
0 0 00000000 00000000 1 2 00002040 0 0 5
00001000 13001000 0
00001004 13001004 0
00002040 13002040 0
00002044 13002044 0
00002048 13002048 0
0 0 00000000 00000000 2 3 00003000 0 0 5
00001000 13001000 0
00001004 13001004 0
00001008 13001008 0
00003000 13003000 0
00003004 13003004 0
0 0 00000000 00000000 0 0 00000000 1 0 10
00001000 13001000 0
00001004 13001004 0
00001008 13001008 0
0000100c 1300100c 0
00001010 13001010 0
00001014 13001014 0
00001018 13001018 0
0000101c 1300101c 0
00001020 13001020 0
00001024 13001024 0
1 0 00000005 000000c0 2 3 00002000 0 2 5
00001000 13006000 0
00001004 13006004 0
00001008 13006008 0
00002000 13007000 0
00002004 13007004 0
1 1 00000005 00000000 0 0 00000000 0 0 4
00001000 13001000 0
00001004 13001004 0
00001008 13001008 0
0000100c 1300100c 0
1 0 00000005 00000000 0 0 00000000 0 3 3
00001000 00000000 c
00001000 00000000 c
00001000 00000000 c
0 0 00000000 00000000 3 4 00005000 0 0 6
00001000 13001000 0
00001004 13001004 0
00001008 13001008 0
0000100c 1300100c 0
00005000 13005000 0
00005004 13005004 0

// ==== verification/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb import fetch_types_pkg::*; import mem_types_pkg::*; ();

  logic         clk_i;
  logic         rst_gen_n;
  logic         scen_rst_n;
  logic         rst_i;
  logic         vm_en_i;
  logic         trap_bypass_mmu_i;
  satp_t        satp_data_i;
  logic         flush_i;
  vaddr_t       next_pc_flush_i;
  logic         alu_branch_taken_i;
  vaddr_t       pc_branch_offset_i;
  logic         is_jump_i;
  vaddr_t       jump_address_i;
  logic         dec_stall_i;
  logic         present_table_req_o;
  ppn_t         present_table_ppn_o;
  logic         ppn_is_present_i;
  logic         rd_req_valid_o;
  paddr_t       mem_req_addr_o;
  access_size_t req_access_size_o;
  logic         mem_gnt_i;
  logic         instr_valid_i;
  cache_line_t  instr_line_i;
  logic         dec_valid_o;
  logic         dec_excpt_o;
  excpt_cause_t dec_excpt_cause_o;
  vaddr_t       dec_pc_o;
  instruction_t dec_instr_o;

  logic [31:0] present_mask;
  logic        active;
  logic        mem_busy;
  integer      seed = 32'hf26fa132;
  int          watchdog_cycles = 0;
  int          tb_errors = 0;

  assign rst_i = rst_gen_n & scen_rst_n;

  // Present table indexed by the low page bits
  assign ppn_is_present_i = present_mask[present_table_ppn_o[4:0]];

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) u_clock_gen (
    .clk_o (clk_i),
    .rst_o (rst_gen_n)
  );

  fetch_top uut (.*);

  fetch_checker u_checker (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .active_i   (active),
    .valid_i    (dec_valid_o),
    .stall_i    (dec_stall_i),
    .excpt_i    (dec_excpt_o),
    .cause_i    (dec_excpt_cause_o),
    .pc_i       (dec_pc_o),
    .instr_i    (dec_instr_o),
    .walk_req_i (present_table_req_o),
    .mem_req_i  (rd_req_valid_o),
    .mem_addr_i (mem_req_addr_o),
    .size_i     (req_access_size_o)
  );

  // Memory model grants first and then returns a whole line
  initial begin
    paddr_t line_addr;
    int     wait_cycles;
    mem_gnt_i     = 1'b0;
    instr_valid_i = 1'b0;
    instr_line_i  = '0;
    mem_busy      = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (rd_req_valid_o && rst_i) begin
        mem_busy    = 1'b1;
        line_addr   = mem_req_addr_o;
        wait_cycles = $unsigned($random(seed)) % 4;
        repeat (wait_cycles) begin
          @(posedge clk_i);
          #1;
        end
        mem_gnt_i = 1'b1;
        @(posedge clk_i);
        #1;
        mem_gnt_i   = 1'b0;
        wait_cycles = 1 + $unsigned($random(seed)) % 4;
        repeat (wait_cycles - 1) begin
          @(posedge clk_i);
          #1;
        end
        for (int w = 0; w < 4; w++) begin
          instr_line_i[w*32 +: 32] = ({12'h0, line_addr} + 32'(w * 4)) ^ 32'h13000000;
        end
        instr_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
        mem_busy      = 1'b0;
      end
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Timeout: decode items did not arrive in %0d cycles", watchdog_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // Skips blank lines and lines starting with #
  task automatic read_data_line(input int fd, output string line, output bit ok);
    int rc;
    ok = 1'b0;
    while (!ok) begin
      rc = $fgets(line, fd);
      if (rc == 0) begin
        break;
      end
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        ok = 1'b1;
      end
    end
  endtask

  task automatic run_scenario(input int kind, input int trigger, input vaddr_t target,
                              input int stall_en, input int walks, input int count);
    int stall_left;
    bit fired;
    bit done;
    stall_left = 0;
    fired      = 1'b0;
    done       = 1'b0;
    scen_rst_n = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    scen_rst_n = 1'b1;
    dec_stall_i = 1'b0;
    u_checker.start_scenario();
    active = 1'b1;
    while (!done) begin
      @(posedge clk_i);
      #1;
      alu_branch_taken_i = 1'b0;
      is_jump_i          = 1'b0;
      flush_i            = 1'b0;
      if (u_checker.seen_count >= count) begin
        done        = 1'b1;
        dec_stall_i = 1'b1;
        active      = 1'b0;
      end else begin
        // A flush is held back until a refill is in flight
        if (!fired && kind != 0 && u_checker.seen_count == trigger &&
            (kind != 3 || rd_req_valid_o)) begin
          fired = 1'b1;
          case (kind)
            1: begin
              alu_branch_taken_i = 1'b1;
              pc_branch_offset_i = target;
            end
            2: begin
              is_jump_i      = 1'b1;
              jump_address_i = target;
            end
            default: begin
              flush_i         = 1'b1;
              next_pc_flush_i = target;
            end
          endcase
        end
        if (stall_en != 0) begin
          if (stall_left == 0 && ($unsigned($random(seed)) % 4) == 0) begin
            stall_left = 1 + $unsigned($random(seed)) % 4;
          end
          dec_stall_i = (stall_left > 0);
          if (stall_left > 0) begin
            stall_left--;
          end
        end
      end
    end
    while (mem_busy || rd_req_valid_o) begin
      @(posedge clk_i);
      #1;
    end
    u_checker.end_scenario(walks);
  endtask

  initial begin
    int          fd;
    string       line;
    bit          ok;
    int          rc;
    int          num_scen;
    int          total;
    int          vm;
    int          bypass;
    int          kind;
    int          trigger;
    int          stall_en;
    int          walks;
    int          count;
    logic [31:0] satp;
    logic [31:0] mask;
    logic [31:0] target;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] cause;
    vm_en_i            = 1'b0;
    trap_bypass_mmu_i  = 1'b0;
    satp_data_i        = '0;
    flush_i            = 1'b0;
    next_pc_flush_i    = '0;
    alu_branch_taken_i = 1'b0;
    pc_branch_offset_i = '0;
    is_jump_i          = 1'b0;
    jump_address_i     = '0;
    dec_stall_i        = 1'b0;
    scen_rst_n         = 1'b1;
    present_mask       = '0;
    active             = 1'b0;
    fd = $fopen("verification/fetch_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open golden file verification/fetch_golden.txt");
      tb_errors++;
    end else begin
      read_data_line(fd, line, ok);
      rc = $sscanf(line, "%d %d", num_scen, total);
      if (!ok || rc != 2) begin
        $display("Golden file has no valid header line");
        tb_errors++;
        num_scen = 0;
      end
      watchdog_cycles = total * 40 + 2000;
      wait (rst_gen_n);
      for (int s = 0; s < num_scen && tb_errors == 0; s++) begin
        read_data_line(fd, line, ok);
        rc = $sscanf(line, "%d %d %h %h %d %d %h %d %d %d", vm, bypass, satp, mask,
                     kind, trigger, target, stall_en, walks, count);
        if (!ok || rc != 10) begin
          $display("Golden file scenario %0d record is malformed", s);
          tb_errors++;
        end else begin
          for (int i = 0; i < count; i++) begin
            read_data_line(fd, line, ok);
            rc = $sscanf(line, "%h %h %h", pc, instr, cause);
            if (!ok || rc != 3) begin
              $display("Golden file scenario %0d item %0d is malformed", s, i);
              tb_errors++;
            end
            u_checker.push_item(pc, instr, excpt_cause_t'(cause));
          end
          vm_en_i           = vm[0];
          trap_bypass_mmu_i = bypass[0];
          satp_data_i       = satp;
          present_mask      = mask;
          run_scenario(kind, trigger, target, stall_en, walks, count);
        end
      end
      $fclose(fd);
    end
    $display("Items checked: %0d, checker errors: %0d, testbench errors: %0d",
             u_checker.item_count, u_checker.error_count, tb_errors);
    if (u_checker.error_count == 0 && tb_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : fetch_tb

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Active low reset released just after an edge
  initial begin
    rst_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b1;
  end

endmodule : tb_clock_gen
